/* hw/cpu_pkg.sv */
// Shared definitions for the five-stage MIPS subset core
// Word and register types, ALU and branch encodings, stage records,
// loader and event records, opcode and function codes
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,                      // Signed compare giving 0 or 1
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI                       // Immediate into upper half
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JUMP
    } branch_kind_e;

    //////////////////////////////////////////////////////////////////////////
    // Pipeline records
    //////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc_plus4;
    } if_id_t;

    typedef struct packed {
        logic         valid;
        word_t        rs_val;
        word_t        rt_val;
        word_t        imm;            // Already sign or zero extended
        logic [25:0]  jidx;           // J target index
        word_t        pc_plus4;
        alu_op_e      alu_op;
        logic         op2_imm;        // Operand 2 from imm, else rt
        branch_kind_e branch;
        logic         mem_write;
        logic         mem_to_reg;     // Result comes from data memory
        logic         reg_write;
        reg_idx_t     dest;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    result;             // ALU result or memory address
        word_t    store_data;
        logic     mem_write;
        logic     mem_to_reg;
        logic     reg_write;
        reg_idx_t dest;
    } ex_mem_t;

    // Write-back and store events
    typedef struct packed {
        reg_idx_t dest;
        word_t    value;
    } reg_write_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    // Loader record with a word address
    typedef struct packed {
        logic  to_dmem;               // 1 for data memory, 0 for instruction memory
        word_t addr;
        word_t data;
    } load_t;

    //////////////////////////////////////////////////////////////////////////
    // Opcode and function codes
    //////////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    localparam logic [5:0] FN_ADDU    = 6'b100001;
    localparam logic [5:0] FN_SUBU    = 6'b100011;
    localparam logic [5:0] FN_SLT     = 6'b101010;

endpackage

/* hw/fetch_unit.sv */
// Fetch stage
// Program counter and instruction memory. Loader writes go in while
// load_en is high. A redirect from execute reloads the PC and drops
// the instruction fetched in the same cycle
`timescale 1ns/1ps

module fetch_unit #(
    parameter int IMEM_WORDS = 256
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             load_en,
    input  cpu_pkg::load_t   load,
    input  logic             redirect_valid,
    input  cpu_pkg::word_t   redirect_pc,
    output cpu_pkg::if_id_t  if_id
);

    localparam int AW = $clog2(IMEM_WORDS);

    cpu_pkg::word_t imem [IMEM_WORDS];
    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc_plus4;
    cpu_pkg::word_t instr;

    assign pc_plus4 = pc + 32'd4;
    assign instr    = imem[pc[AW+1:2]];   // Word index from the byte PC

    // Loader port into instruction memory
    always_ff @(posedge clk) begin
        if (load_en && !load.to_dmem) begin
            imem[load.addr[AW-1:0]] <= load.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= '0;
            if_id.valid <= 1'b0;
        end else if (load_en) begin
            pc          <= '0;            // Hold at reset vector while loading
            if_id.valid <= 1'b0;
        end else if (redirect_valid) begin
            pc          <= redirect_pc;
            if_id.valid <= 1'b0;          // Wrong-path fetch squashed
        end else begin
            pc             <= pc_plus4;
            if_id.valid    <= 1'b1;
            if_id.instr    <= instr;
            if_id.pc_plus4 <= pc_plus4;
        end
    end

endmodule

/* hw/decoder.sv */
// Decode stage
// Splits the instruction, looks up control fields for the kept subset
// and reads both source registers. Registers the ID/EX record, dropped
// when execute redirects
`timescale 1ns/1ps

module decoder (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::if_id_t   if_id,
    input  logic              squash,
    output cpu_pkg::reg_idx_t rs_idx,
    output cpu_pkg::reg_idx_t rt_idx,
    input  cpu_pkg::word_t    rs_val,
    input  cpu_pkg::word_t    rt_val,
    output cpu_pkg::id_ex_t   id_ex
);

    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic [15:0]       imm16;
    cpu_pkg::reg_idx_t rd_idx;
    cpu_pkg::id_ex_t   dec;

    // Instruction fields
    assign opcode = if_id.instr[31:26];
    assign rs_idx = if_id.instr[25:21];
    assign rt_idx = if_id.instr[20:16];
    assign rd_idx = if_id.instr[15:11];
    assign funct  = if_id.instr[5:0];
    assign imm16  = if_id.instr[15:0];

    always_comb begin
        dec.valid      = if_id.valid && !squash;
        dec.rs_val     = rs_val;
        dec.rt_val     = rt_val;
        dec.imm        = {{16{imm16[15]}}, imm16};  // Sign extend by default
        dec.jidx       = if_id.instr[25:0];
        dec.pc_plus4   = if_id.pc_plus4;
        dec.alu_op     = cpu_pkg::ALU_ADD;
        dec.op2_imm    = 1'b0;
        dec.branch     = cpu_pkg::BR_NONE;
        dec.mem_write  = 1'b0;
        dec.mem_to_reg = 1'b0;
        dec.reg_write  = 1'b0;
        dec.dest       = rt_idx;              // I-type writes rt

        case (opcode)
            cpu_pkg::OP_SPECIAL: begin
                dec.dest = rd_idx;            // R-type writes rd
                case (funct)
                    cpu_pkg::FN_ADDU: begin
                        dec.alu_op    = cpu_pkg::ALU_ADD;
                        dec.reg_write = 1'b1;
                    end
                    cpu_pkg::FN_SUBU: begin
                        dec.alu_op    = cpu_pkg::ALU_SUB;
                        dec.reg_write = 1'b1;
                    end
                    cpu_pkg::FN_SLT: begin
                        dec.alu_op    = cpu_pkg::ALU_SLT;
                        dec.reg_write = 1'b1;
                    end
                    default: ;                // Unknown funct runs as a bubble
                endcase
            end
            cpu_pkg::OP_ADDIU: begin
                dec.op2_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            cpu_pkg::OP_SLTI: begin
                dec.alu_op    = cpu_pkg::ALU_SLT;
                dec.op2_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            cpu_pkg::OP_ANDI, cpu_pkg::OP_ORI, cpu_pkg::OP_XORI: begin
                // Logical immediates are zero filled
                dec.imm       = {16'd0, imm16};
                dec.alu_op    = (opcode == cpu_pkg::OP_ANDI) ? cpu_pkg::ALU_AND :
                                (opcode == cpu_pkg::OP_ORI)  ? cpu_pkg::ALU_OR  :
                                                               cpu_pkg::ALU_XOR;
                dec.op2_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            cpu_pkg::OP_LUI: begin
                dec.alu_op    = cpu_pkg::ALU_LUI;
                dec.op2_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            cpu_pkg::OP_LW: begin
                dec.op2_imm    = 1'b1;        // Address is rs plus offset
                dec.mem_to_reg = 1'b1;
                dec.reg_write  = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                dec.op2_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            cpu_pkg::OP_BEQ: begin
                dec.alu_op = cpu_pkg::ALU_SUB;  // Compare rs against rt
                dec.branch = cpu_pkg::BR_BEQ;
            end
            cpu_pkg::OP_BNE: begin
                dec.alu_op = cpu_pkg::ALU_SUB;
                dec.branch = cpu_pkg::BR_BNE;
            end
            cpu_pkg::OP_J: dec.branch = cpu_pkg::BR_JUMP;
            default: ;
        endcase

        // Writes to r0 are dropped here
        if (dec.dest == '0) begin
            dec.reg_write = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= dec;
        end
    end

endmodule

/* hw/reg_file.sv */
// Register file
// 32 general registers, two combinational read ports, one write port.
// r0 reads as zero and a same-cycle write is seen by the reads
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::reg_idx_t   rs_idx,
    input  cpu_pkg::reg_idx_t   rt_idx,
    output cpu_pkg::word_t      rs_val,
    output cpu_pkg::word_t      rt_val,
    input  logic                wb_valid,
    input  cpu_pkg::reg_write_t wb
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};           // Architectural state starts clear
        end else if (wb_valid && wb.dest != '0) begin
            regs[wb.dest] <= wb.value;
        end
    end

    // Read ports with write bypass
    always_comb begin
        if (rs_idx == '0) begin
            rs_val = '0;
        end else if (wb_valid && wb.dest == rs_idx) begin
            rs_val = wb.value;                // Write lands before the read
        end else begin
            rs_val = regs[rs_idx];
        end

        if (rt_idx == '0) begin
            rt_val = '0;
        end else if (wb_valid && wb.dest == rt_idx) begin
            rt_val = wb.value;
        end else begin
            rt_val = regs[rt_idx];
        end
    end

endmodule

/* hw/execute_unit.sv */
// Execute stage
// ALU, branch and jump resolution. A taken branch or jump redirects
// fetch in the same cycle; the EX/MEM record is registered
`timescale 1ns/1ps

module execute_unit (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::id_ex_t   id_ex,
    output logic              redirect_valid,
    output cpu_pkg::word_t    redirect_pc,
    output cpu_pkg::ex_mem_t  ex_mem
);

    cpu_pkg::word_t op2;
    cpu_pkg::word_t sum;
    cpu_pkg::word_t diff;
    cpu_pkg::word_t alu_res;
    cpu_pkg::word_t br_target;
    cpu_pkg::word_t j_target;
    logic           lt;
    logic           eq;
    logic           taken;

    ///////////////////////////////////////////////////////////////////////////
    // ALU
    ///////////////////////////////////////////////////////////////////////////

    assign op2  = id_ex.op2_imm ? id_ex.imm : id_ex.rt_val;
    assign sum  = id_ex.rs_val + op2;
    assign diff = id_ex.rs_val - op2;
    assign eq   = (diff == '0);                  // BEQ and BNE test
    assign lt   = $signed(id_ex.rs_val) < $signed(op2);

    always_comb begin
        case (id_ex.alu_op)
            cpu_pkg::ALU_ADD: alu_res = sum;
            cpu_pkg::ALU_SUB: alu_res = diff;
            cpu_pkg::ALU_SLT: alu_res = {31'd0, lt};
            cpu_pkg::ALU_AND: alu_res = id_ex.rs_val & op2;
            cpu_pkg::ALU_OR:  alu_res = id_ex.rs_val | op2;
            cpu_pkg::ALU_XOR: alu_res = id_ex.rs_val ^ op2;
            cpu_pkg::ALU_LUI: alu_res = {op2[15:0], 16'd0};
            default:          alu_res = sum;
        endcase
    end

    ///////////////////////////////////////////////////////////////////////////
    // Branch resolution and next PC
    ///////////////////////////////////////////////////////////////////////////

    assign br_target = id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};
    assign j_target  = {id_ex.pc_plus4[31:28], id_ex.jidx, 2'b00};  // Same 256MB region

    always_comb begin
        case (id_ex.branch)
            cpu_pkg::BR_BEQ:  taken = eq;
            cpu_pkg::BR_BNE:  taken = !eq;
            cpu_pkg::BR_JUMP: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign redirect_valid = id_ex.valid && taken;
    assign redirect_pc    = (id_ex.branch == cpu_pkg::BR_JUMP) ? j_target : br_target;

    // EX/MEM record
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.result     <= alu_res;
            ex_mem.store_data <= id_ex.rt_val;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.mem_to_reg <= id_ex.mem_to_reg;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.dest       <= id_ex.dest;
        end
    end

endmodule

/* hw/mem_stage.sv */
// Memory stage
// Word-wide data memory written by stores or by the loader. Picks the
// loaded word or the ALU result and registers the write-back event
`timescale 1ns/1ps

module mem_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load_en,
    input  cpu_pkg::load_t       load,
    input  cpu_pkg::ex_mem_t     ex_mem,
    output logic                 store_valid,
    output cpu_pkg::store_t      store,
    output logic                 wb_valid,
    output cpu_pkg::reg_write_t  wb
);

    localparam int AW = $clog2(DMEM_WORDS);

    cpu_pkg::word_t dmem [DMEM_WORDS];
    cpu_pkg::word_t rd_word;

    assign store_valid = ex_mem.valid && ex_mem.mem_write;
    assign store.addr  = ex_mem.result;
    assign store.data  = ex_mem.store_data;
    assign rd_word     = dmem[ex_mem.result[AW+1:2]];   // Byte address to word index

    always_ff @(posedge clk) begin
        if (load_en && load.to_dmem) begin
            dmem[load.addr[AW-1:0]] <= load.data;      // Loader address is already a word
        end else if (store_valid) begin
            dmem[ex_mem.result[AW+1:2]] <= ex_mem.store_data;
        end
    end

    // MEM/WB event
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_mem.valid && ex_mem.reg_write;
            wb.dest  <= ex_mem.dest;
            wb.value <= ex_mem.mem_to_reg ? rd_word : ex_mem.result;
        end
    end

endmodule

/* hw/cpu_top.sv */
// Five-stage MIPS subset core
// Fetch, decode, execute, memory, write-back. No forwarding and no
// interlock; taken branches and jumps squash the two younger slots.
// External loader fills both memories while load_en is high
`timescale 1ns/1ps

module cpu_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load_en,
    input  cpu_pkg::load_t       load,
    output logic                 retire_valid,
    output cpu_pkg::reg_write_t  retire,
    output logic                 store_valid,
    output cpu_pkg::store_t      store
);

    cpu_pkg::if_id_t   if_id;
    cpu_pkg::id_ex_t   id_ex;
    cpu_pkg::ex_mem_t  ex_mem;
    cpu_pkg::reg_idx_t rs_idx;
    cpu_pkg::reg_idx_t rt_idx;
    cpu_pkg::word_t    rs_val;
    cpu_pkg::word_t    rt_val;
    logic              redirect_valid;
    cpu_pkg::word_t    redirect_pc;

    ///////////////////////////////////////////////////////////////////////////
    // Fetch and decode
    ///////////////////////////////////////////////////////////////////////////

    fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .clk            (clk),
        .rst            (rst),
        .load_en        (load_en),
        .load           (load),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .if_id          (if_id)
    );

    decoder u_decode (
        .clk    (clk),
        .rst    (rst),
        .if_id  (if_id),
        .squash (redirect_valid),   // Same strobe that reloads the PC
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .id_ex  (id_ex)
    );

    // Write port fed straight from the retire event
    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .rs_val   (rs_val),
        .rt_val   (rt_val),
        .wb_valid (retire_valid),
        .wb       (retire)
    );

    ///////////////////////////////////////////////////////////////////////////
    // Execute and memory
    ///////////////////////////////////////////////////////////////////////////

    execute_unit u_exec (
        .clk            (clk),
        .rst            (rst),
        .id_ex          (id_ex),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .ex_mem         (ex_mem)
    );

    mem_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
        .clk         (clk),
        .rst         (rst),
        .load_en     (load_en),
        .load        (load),
        .ex_mem      (ex_mem),
        .store_valid (store_valid),
        .store       (store),
        .wb_valid    (retire_valid),
        .wb          (retire)
    );

endmodule

/* dv/cpu_assert.sv */
// Protocol checks for the core's event ports
// Bound into cpu_top; loading keeps the pipeline quiet, strobes stay
// known after reset and r0 never retires
`timescale 1ns/1ps

module cpu_assert (
    input logic                clk,
    input logic                rst,
    input logic                load_en,
    input logic                retire_valid,
    input cpu_pkg::reg_write_t retire,
    input logic                store_valid
);

    // Decoder drops r0 writes before they reach write-back
    a_no_r0_retire: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire.dest != '0)
        else $error("retire event names r0");

    a_idle_while_loading: assert property (@(posedge clk) disable iff (rst)
        load_en |-> (!retire_valid && !store_valid))   // Fetch emits bubbles only
        else $error("event strobe while load_en is high");

    a_strobes_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(retire_valid) && !$isunknown(store_valid))
        else $error("event strobe is unknown after reset");

endmodule

bind cpu_top cpu_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .load_en      (load_en),
    .retire_valid (retire_valid),
    .retire       (retire),
    .store_valid  (store_valid)
);

/* dv/cpu_tb.sv */
// Testbench for the five-stage MIPS subset core
// Reads program, data and expected events from the stimulus file,
// loads both memories, then matches every retire and store strobe
// in order against the expected queues
`timescale 1ns/1ps

module cpu_tb;

    localparam string STIM_FILE    = "dv/cpu_stimulus.txt";
    localparam int    WAIT_CYCLES  = 200;     // Event loop timeout
    localparam int    QUIET_CYCLES = 20;      // Window for stray events
    localparam int    MAX_RECORDS  = 1000;    // Bound on file tokens

    logic                clk;
    logic                rst;
    logic                load_en;
    cpu_pkg::load_t      load;
    logic                retire_valid;
    cpu_pkg::reg_write_t retire;
    logic                store_valid;
    cpu_pkg::store_t     store;

    // Expected traffic from the stimulus file
    cpu_pkg::load_t      load_q[$];
    cpu_pkg::reg_write_t retire_q[$];
    cpu_pkg::store_t     store_q[$];

    cpu_top #(
        .IMEM_WORDS (256),
        .DMEM_WORDS (256)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .load_en      (load_en),
        .load         (load),
        .retire_valid (retire_valid),
        .retire       (retire),
        .store_valid  (store_valid),
        .store        (store)
    );

    always #5 clk = ~clk;                     // 10 ns period

    ////////////////////////////////////////////////////////////////////////////
    // Failure path and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_retire(input cpu_pkg::reg_write_t exp,
                                input cpu_pkg::reg_write_t act);
        if (act !== exp) begin
            $display("MISMATCH time=%0t signal=retire expected r%0d=%08h actual r%0d=%08h",
                     $time, exp.dest, exp.value, act.dest, act.value);
            abort_run();
        end
    endtask

    task automatic check_store(input cpu_pkg::store_t exp, input cpu_pkg::store_t act);
        if (act !== exp) begin
            $display("MISMATCH time=%0t signal=store expected [%08h]=%08h actual [%08h]=%08h",
                     $time, exp.addr, exp.data, act.addr, act.data);
            abort_run();
        end
    endtask

    // One look at both event ports, called between clock edges
    task automatic sample_events();
        if (retire_valid) begin
            if (retire_q.size() == 0) begin
                $display("Unexpected retire at %0t: r%0d = %08h",
                         $time, retire.dest, retire.value);
                abort_run();
            end else begin
                check_retire(retire_q.pop_front(), retire);
            end
        end
        if (store_valid) begin
            if (store_q.size() == 0) begin
                $display("Unexpected store at %0t: [%08h] = %08h",
                         $time, store.addr, store.data);
                abort_run();
            end else begin
                check_store(store_q.pop_front(), store);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus file and loader
    ////////////////////////////////////////////////////////////////////////////

    task automatic read_stimulus();
        int                  fd;
        int                  n;
        int                  tokens;
        bit                  done;
        logic [63:0]         tag;
        logic [8*256-1:0]    rest;
        logic [31:0]         f0;
        logic [31:0]         f1;
        logic [31:0]         f2;
        cpu_pkg::load_t      ld;
        cpu_pkg::reg_write_t rw;
        cpu_pkg::store_t     st;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            abort_run();
        end else begin
            done   = 1'b0;
            tokens = 0;
            while (!done && tokens < MAX_RECORDS) begin
                n = $fscanf(fd, "%s", tag);
                tokens++;
                if (n != 1) begin
                    $display("Stimulus file ends without an end record");
                    abort_run();
                end else if (tag == "#") begin
                    n = $fgets(rest, fd);              // Comment to end of line
                end else if (tag == "load") begin
                    n = $fscanf(fd, "%h %h %h", f0, f1, f2);
                    if (n != 3) begin
                        $display("Malformed load record in stimulus file");
                        abort_run();
                    end else begin
                        ld.to_dmem = f0[0];
                        ld.addr    = f1;
                        ld.data    = f2;
                        load_q.push_back(ld);
                    end
                end else if (tag == "retire") begin
                    n = $fscanf(fd, "%h %h", f0, f1);
                    if (n != 2) begin
                        $display("Malformed retire record in stimulus file");
                        abort_run();
                    end else begin
                        rw.dest  = f0[4:0];
                        rw.value = f1;
                        retire_q.push_back(rw);
                    end
                end else if (tag == "store") begin
                    n = $fscanf(fd, "%h %h", f0, f1);
                    if (n != 2) begin
                        $display("Malformed store record in stimulus file");
                        abort_run();
                    end else begin
                        st.addr = f0;
                        st.data = f1;
                        store_q.push_back(st);
                    end
                end else if (tag == "end") begin
                    done = 1'b1;
                end else begin
                    $display("Unknown record tag in stimulus file: %s", tag);
                    abort_run();
                end
            end
            $fclose(fd);
            if (!done) begin
                $display("Stimulus file has too many records");
                abort_run();
            end
        end
    endtask

    // One loader write per cycle with load_en held high
    task automatic apply_loads();
        foreach (load_q[i]) begin
            @(negedge clk);
            load_en = 1'b1;
            load    = load_q[i];
        end
        @(negedge clk);
        load_en = 1'b0;                       // First fetch follows this
        load    = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int cycles;

        clk     = 1'b0;
        rst     = 1'b1;
        load_en = 1'b0;
        load    = '0;

        read_stimulus();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        apply_loads();

        cycles = 0;
        while ((retire_q.size() != 0 || store_q.size() != 0) && cycles < WAIT_CYCLES) begin
            @(negedge clk);
            sample_events();
            cycles++;
        end

        if (retire_q.size() != 0 || store_q.size() != 0) begin
            $display("Timed out after %0d cycles with %0d retire and %0d store events missing",
                     WAIT_CYCLES, retire_q.size(), store_q.size());
            abort_run();
        end else begin
            // Squashed and skipped slots must stay silent
            for (int i = 0; i < QUIET_CYCLES; i++) begin
                @(negedge clk);
                sample_events();
            end
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

/* list.f */
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/mem_stage.sv
hw/cpu_top.sv
dv/cpu_assert.sv
dv/cpu_tb.sv

/* Makefile */
# Verilator build for the MIPS subset core and its testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES   := $(wildcard hw/*.sv dv/*.sv)
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Run from the project root so the stimulus path resolves
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* dv/cpu_stimulus.txt */
# load <0 imem, 1 dmem> <word addr> <data> | retire <dest> <value> | store <byte addr> <data>
# All numbers hex, a lone # starts a comment to end of line, end closes the file
load 0 00 24010005   # addiu r1, r0, 5
load 0 01 2402fffd   # addiu r2, r0, -3
load 0 02 3c031234   # lui   r3, 0x1234
load 0 03 34048001   # ori   r4, r0, 0x8001
load 0 04 00222821   # addu  r5, r1, r2
load 0 05 34635678   # ori   r3, r3, 0x5678
load 0 06 3046f0f0   # andi  r6, r2, 0xf0f0
load 0 07 3887ffff   # xori  r7, r4, 0xffff
load 0 08 00224023   # subu  r8, r1, r2
load 0 09 0041482a   # slt   r9, r2, r1
load 0 0a 284afffe   # slti  r10, r2, -2
load 0 0b 240c0040   # addiu r12, r0, 0x40
load 0 0c 8c0d0010   # lw    r13, 0x10(r0) preloaded word
load 0 0d 24200007   # addiu r0, r1, 7 no event
load 0 0e ad830004   # sw    r3, 4(r12)
load 0 0f 8d8e0004   # lw    r14, 4(r12) reads the stored word
load 0 10 00017821   # addu  r15, r0, r1
load 0 11 00a35821   # addu  r11, r5, r3
load 0 12 112a0002   # beq   r9, r10, +2 taken
load 0 13 24140001   # addiu r20 squashed
load 0 14 24150002   # addiu r21 squashed
load 0 15 14220003   # bne   r1, r2, +3 taken
load 0 16 24160003   # addiu r22 squashed
load 0 17 24170004   # addiu r23 squashed
load 0 18 24180005   # addiu r24 skipped
load 0 19 10220005   # beq   r1, r2 not taken
load 0 1a 24100077   # addiu r16, r0, 0x77
load 0 1b 0800001f   # j     0x7c
load 0 1c 24190006   # addiu r25 squashed
load 0 1d 241a0007   # addiu r26 squashed
load 0 1e 241b0008   # addiu r27 skipped
load 0 1f 01f08821   # addu  r17, r15, r16
load 0 20 08000020   # j     0x80 self loop
load 1 04 cafef00d   # data word at byte 0x10
retire 01 00000005
retire 02 fffffffd
retire 03 12340000
retire 04 00008001
retire 05 00000002
retire 03 12345678
retire 06 0000f0f0
retire 07 00007ffe
retire 08 00000008
retire 09 00000001
retire 0a 00000001
retire 0c 00000040
retire 0d cafef00d
retire 0e 12345678
retire 0f 00000005
retire 0b 1234567a
retire 10 00000077
retire 11 0000007c
store 00000044 12345678
end
